// File: hdl/tapc_dr_chain.sv
// TAP data register
// Captures a parallel value and shifts it out LSB first, TDI into the MSB

`timescale 1ns/1ps

module tapc_dr_chain #(
    parameter int WIDTH = 32
) (
    input  logic                    tapc_tck,
    input  logic                    tapc_trst_n,
    input  logic                    soft_rst_n_i,
    input  logic                    sel_i,
    input  tapc_pkg::tapc_dr_ctrl_t dr_ctrl_i,
    input  logic                    tdi_i,
    input  logic [WIDTH-1:0]        parallel_i,
    output logic                    tdo_o
);

    logic [WIDTH-1:0] sr_q;
    // TDI prepended, so a slice gives the shifted value for any width
    logic [WIDTH:0]   sr_ext;

    assign sr_ext = {tdi_i, sr_q};

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            sr_q <= '0;
        end else if (!soft_rst_n_i) begin
            sr_q <= '0;
        end else if (sel_i && dr_ctrl_i.capture) begin
            sr_q <= parallel_i;
        end else if (sel_i && dr_ctrl_i.shift) begin
            sr_q <= sr_ext[WIDTH:1];
        end
    end

    // Serial out
    assign tdo_o = sr_q[0];

endmodule : tapc_dr_chain

// File: hdl/tapc_fsm.sv
// TAP state machine
// Steps on TMS, registers DR and IR shift strobes from the next state,
// decodes IR phases and makes the falling-edge soft reset

`timescale 1ns/1ps

module tapc_fsm (
    input  logic                    tapc_tck,
    input  logic                    tapc_trst_n,
    input  logic                    tms_i,
    output tapc_pkg::tapc_dr_ctrl_t dr_ctrl_o,
    output logic                    ir_capture_o,
    output logic                    ir_shift_o,
    output logic                    ir_update_o,
    output logic                    ir_shift_q_o,
    output logic                    soft_rst_n_o
);
    import tapc_pkg::*;

    // Current and next TAP state
    tapc_state_e   state_q;
    tapc_state_e   state_nxt;

    // Strobes, registered
    tapc_dr_ctrl_t dr_ctrl_q;
    tapc_dr_ctrl_t dr_ctrl_nxt;
    logic          ir_shift_q;

    logic          soft_rst_n_q;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= TAPC_ST_RESET;
        end else begin
            state_q <= state_nxt;
        end
    end

    // IEEE 1149.1 transition table
    always_comb begin
        case (state_q)
            TAPC_ST_RESET:      state_nxt = tms_i ? TAPC_ST_RESET     : TAPC_ST_IDLE;
            TAPC_ST_IDLE:       state_nxt = tms_i ? TAPC_ST_DR_SEL    : TAPC_ST_IDLE;
            TAPC_ST_DR_SEL:     state_nxt = tms_i ? TAPC_ST_IR_SEL    : TAPC_ST_DR_CAPTURE;
            TAPC_ST_DR_CAPTURE: state_nxt = tms_i ? TAPC_ST_DR_EXIT1  : TAPC_ST_DR_SHIFT;
            TAPC_ST_DR_SHIFT:   state_nxt = tms_i ? TAPC_ST_DR_EXIT1  : TAPC_ST_DR_SHIFT;
            TAPC_ST_DR_EXIT1:   state_nxt = tms_i ? TAPC_ST_DR_UPDATE : TAPC_ST_DR_PAUSE;
            TAPC_ST_DR_PAUSE:   state_nxt = tms_i ? TAPC_ST_DR_EXIT2  : TAPC_ST_DR_PAUSE;
            TAPC_ST_DR_EXIT2:   state_nxt = tms_i ? TAPC_ST_DR_UPDATE : TAPC_ST_DR_SHIFT;
            TAPC_ST_DR_UPDATE:  state_nxt = tms_i ? TAPC_ST_DR_SEL    : TAPC_ST_IDLE;
            TAPC_ST_IR_SEL:     state_nxt = tms_i ? TAPC_ST_RESET     : TAPC_ST_IR_CAPTURE;
            TAPC_ST_IR_CAPTURE: state_nxt = tms_i ? TAPC_ST_IR_EXIT1  : TAPC_ST_IR_SHIFT;
            TAPC_ST_IR_SHIFT:   state_nxt = tms_i ? TAPC_ST_IR_EXIT1  : TAPC_ST_IR_SHIFT;
            TAPC_ST_IR_EXIT1:   state_nxt = tms_i ? TAPC_ST_IR_UPDATE : TAPC_ST_IR_PAUSE;
            TAPC_ST_IR_PAUSE:   state_nxt = tms_i ? TAPC_ST_IR_EXIT2  : TAPC_ST_IR_PAUSE;
            TAPC_ST_IR_EXIT2:   state_nxt = tms_i ? TAPC_ST_IR_UPDATE : TAPC_ST_IR_SHIFT;
            TAPC_ST_IR_UPDATE:  state_nxt = tms_i ? TAPC_ST_DR_SEL    : TAPC_ST_IDLE;
            // Unknown encoding holds
            default:            state_nxt = state_q;
        endcase
    end

    // --------------------
    // Registered strobes
    // --------------------
    // Taken from the next state so they line up with the state itself
    always_comb begin
        dr_ctrl_nxt.capture = (state_nxt == TAPC_ST_DR_CAPTURE);
        dr_ctrl_nxt.shift   = (state_nxt == TAPC_ST_DR_SHIFT);
        dr_ctrl_nxt.update  = (state_nxt == TAPC_ST_DR_UPDATE);
    end

    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            dr_ctrl_q  <= '0;
            ir_shift_q <= 1'b0;
        end else begin
            dr_ctrl_q  <= dr_ctrl_nxt;
            ir_shift_q <= (state_nxt == TAPC_ST_IR_SHIFT);
        end
    end

    // IR phase flags, decoded straight from the state
    assign ir_capture_o = (state_q == TAPC_ST_IR_CAPTURE);
    assign ir_shift_o   = (state_q == TAPC_ST_IR_SHIFT);
    assign ir_update_o  = (state_q == TAPC_ST_IR_UPDATE);

    // Soft reset, low half a cycle behind Test-Logic-Reset
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            soft_rst_n_q <= 1'b0;
        end else begin
            soft_rst_n_q <= (state_q != TAPC_ST_RESET);
        end
    end

    assign dr_ctrl_o    = dr_ctrl_q;
    assign ir_shift_q_o = ir_shift_q;
    assign soft_rst_n_o = soft_rst_n_q;

    // --------------------
    // Assertions
    // --------------------
    a_tms_known : assert property (
        @(posedge tapc_tck) disable iff (!tapc_trst_n)
        !$isunknown(tms_i)
    ) else $error("tapc_fsm: TMS unknown");

    // Strobes name distinct states, so at most one is up
    a_strobe_onehot0 : assert property (
        @(posedge tapc_tck) disable iff (!tapc_trst_n)
        $onehot0({dr_ctrl_q, ir_shift_q})
    ) else $error("tapc_fsm: more than one strobe active");

endmodule : tapc_fsm

// File: hdl/tapc_ir.sv
// TAP instruction path
// Instruction shift register, falling-edge instruction register and
// decoder to data source select and chain id

`timescale 1ns/1ps

module tapc_ir (
    input  logic                                  tapc_tck,
    input  logic                                  tapc_trst_n,
    input  logic                                  soft_rst_n_i,
    input  logic                                  tdi_i,
    input  logic                                  ir_capture_i,
    input  logic                                  ir_shift_i,
    input  logic                                  ir_update_i,
    output logic                                  ir_tdo_o,
    output tapc_pkg::tapc_dr_sel_t                dr_sel_o,
    output logic [tapc_pkg::TAPC_CH_ID_WIDTH-1:0] ch_id_o
);
    import tapc_pkg::*;

    tapc_instr_t ir_sr_q;
    tapc_instr_t ir_q;

    // --------------------
    // Shift register
    // --------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_sr_q <= '0;
        end else if (!soft_rst_n_i) begin
            ir_sr_q <= '0;
        end else if (ir_capture_i) begin
            ir_sr_q <= TAPC_IR_CAPTURE_VALUE;
        end else if (ir_shift_i) begin
            // TDI enters at the MSB, LSB leaves first
            ir_sr_q <= {tdi_i, ir_sr_q[TAPC_IR_WIDTH-1:1]};
        end
    end

    assign ir_tdo_o = ir_sr_q[0];

    // Instruction register, updated on the falling edge
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_q <= TAPC_INSTR_IDCODE;
        end else if (!soft_rst_n_i) begin
            ir_q <= TAPC_INSTR_IDCODE;
        end else if (ir_update_i) begin
            ir_q <= ir_sr_q;
        end
    end

    // --------------------
    // Decoder
    // --------------------
    always_comb begin
        dr_sel_o = '0;
        ch_id_o  = '0;
        case (ir_q)
            TAPC_INSTR_IDCODE:     dr_sel_o.idcode = 1'b1;
            TAPC_INSTR_BLD_ID:     dr_sel_o.bld_id = 1'b1;
            TAPC_INSTR_SCU_ACCESS: dr_sel_o.scu    = 1'b1;
            TAPC_INSTR_BYPASS:     dr_sel_o.bypass = 1'b1;
            TAPC_INSTR_DTMCS: begin
                dr_sel_o.dmi = 1'b1;
                ch_id_o      = TAPC_CH_ID_DTMCS;
            end
            TAPC_INSTR_DMI_ACCESS: begin
                dr_sel_o.dmi = 1'b1;
                ch_id_o      = TAPC_CH_ID_DMI;
            end
            // Unlisted codes fall back to bypass
            default:               dr_sel_o.bypass = 1'b1;
        endcase
    end

    a_sel_onehot : assert property (
        @(posedge tapc_tck) disable iff (!tapc_trst_n)
        $onehot(dr_sel_o)
    ) else $error("tapc_ir: data select not one-hot");

endmodule : tapc_ir

// File: hdl/tapc_pkg.sv
// JTAG TAP controller shared definitions
// TAP states, instruction codes, register widths and control structs

package tapc_pkg;

    // --------------------
    // TAP state encoding
    // --------------------
    typedef enum logic [3:0] {
        TAPC_ST_RESET      = 4'd0,
        TAPC_ST_IDLE       = 4'd1,
        TAPC_ST_DR_SEL     = 4'd2,
        TAPC_ST_DR_CAPTURE = 4'd3,
        TAPC_ST_DR_SHIFT   = 4'd4,
        TAPC_ST_DR_EXIT1   = 4'd5,
        TAPC_ST_DR_PAUSE   = 4'd6,
        TAPC_ST_DR_EXIT2   = 4'd7,
        TAPC_ST_DR_UPDATE  = 4'd8,
        TAPC_ST_IR_SEL     = 4'd9,
        TAPC_ST_IR_CAPTURE = 4'd10,
        TAPC_ST_IR_SHIFT   = 4'd11,
        TAPC_ST_IR_EXIT1   = 4'd12,
        TAPC_ST_IR_PAUSE   = 4'd13,
        TAPC_ST_IR_EXIT2   = 4'd14,
        TAPC_ST_IR_UPDATE  = 4'd15
    } tapc_state_e;

    // --------------------
    // Instruction register
    // --------------------
    localparam int TAPC_IR_WIDTH = 5;

    typedef logic [TAPC_IR_WIDTH-1:0] tapc_instr_t;

    // Fixed pattern per IEEE 1149.1, two LSBs are 01
    localparam tapc_instr_t TAPC_IR_CAPTURE_VALUE = 5'b00001;

    localparam tapc_instr_t TAPC_INSTR_IDCODE     = 5'h01;
    localparam tapc_instr_t TAPC_INSTR_BLD_ID     = 5'h04;
    localparam tapc_instr_t TAPC_INSTR_SCU_ACCESS = 5'h09;
    localparam tapc_instr_t TAPC_INSTR_DTMCS      = 5'h10;
    localparam tapc_instr_t TAPC_INSTR_DMI_ACCESS = 5'h11;
    localparam tapc_instr_t TAPC_INSTR_BYPASS     = 5'h1F;

    // --------------------
    // Data registers
    // --------------------
    localparam int TAPC_DR_BYPASS_WIDTH = 1;
    localparam int TAPC_DR_IDCODE_WIDTH = 32;
    localparam int TAPC_DR_BLD_ID_WIDTH = 32;

    localparam logic [TAPC_DR_BLD_ID_WIDTH-1:0] TAPC_BLD_ID_VALUE = 32'h5A7C_0104;

    // Chain ids seen by the debug side
    localparam int TAPC_CH_ID_WIDTH = 2;

    localparam logic [TAPC_CH_ID_WIDTH-1:0] TAPC_CH_ID_DTMCS = 2'd1;
    localparam logic [TAPC_CH_ID_WIDTH-1:0] TAPC_CH_ID_DMI   = 2'd2;

    // --------------------
    // Control structs
    // --------------------
    // Registered DR strobes, each high for the whole state it names
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
    } tapc_dr_ctrl_t;

    // One-hot data source select
    typedef struct packed {
        logic bypass;
        logic idcode;
        logic bld_id;
        logic dmi;
        logic scu;
    } tapc_dr_sel_t;

    // External scan chain port
    typedef struct packed {
        logic                        dmi_sel;
        logic                        scu_sel;
        logic [TAPC_CH_ID_WIDTH-1:0] ch_id;
        logic                        capture;
        logic                        shift;
        logic                        update;
        logic                        tdi;
    } tapc_chain_ctrl_t;

endpackage : tapc_pkg

// File: hdl/tapc_tdo_mux.sv
// TAP read data path
// Picks the serial source and drives TDO and TDO enable from the falling edge

`timescale 1ns/1ps

module tapc_tdo_mux (
    input  logic                    tapc_tck,
    input  logic                    tapc_trst_n,
    input  logic                    soft_rst_n_i,
    input  tapc_pkg::tapc_dr_sel_t  dr_sel_i,
    input  tapc_pkg::tapc_dr_ctrl_t dr_ctrl_i,
    input  logic                    ir_shift_q_i,
    input  logic                    ir_tdo_i,
    input  logic                    bypass_tdo_i,
    input  logic                    idcode_tdo_i,
    input  logic                    bld_id_tdo_i,
    input  logic                    chain_tdo_i,
    output logic                    tdo_o,
    output logic                    tdo_en_o
);

    logic dr_out;
    logic tdo_nxt;
    logic tdo_q;
    logic tdo_en_q;

    // Data source, select is one-hot
    always_comb begin
        dr_out = bypass_tdo_i;
        if (dr_sel_i.idcode) begin
            dr_out = idcode_tdo_i;
        end else if (dr_sel_i.bld_id) begin
            dr_out = bld_id_tdo_i;
        end else if (dr_sel_i.dmi || dr_sel_i.scu) begin
            // Both debug chains share the external port
            dr_out = chain_tdo_i;
        end
    end

    assign tdo_nxt = dr_ctrl_i.shift ? dr_out
                   : ir_shift_q_i    ? ir_tdo_i
                   :                   1'b0;

    // --------------------
    // Falling-edge output
    // --------------------
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else if (!soft_rst_n_i) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else begin
            tdo_q    <= tdo_nxt;
            tdo_en_q <= dr_ctrl_i.shift | ir_shift_q_i;
        end
    end

    assign tdo_o    = tdo_q;
    assign tdo_en_o = tdo_en_q;

    // Chain return must be clean when it is sampled onto TDO
    a_chain_tdo_known : assert property (
        @(negedge tapc_tck) disable iff (!tapc_trst_n)
        (dr_ctrl_i.shift && (dr_sel_i.dmi || dr_sel_i.scu)) |-> !$isunknown(chain_tdo_i)
    ) else $error("tapc_tdo_mux: chain TDO unknown during shift");

endmodule : tapc_tdo_mux

// File: hdl/tapc_top.sv
// JTAG TAP controller top level
// State machine, instruction path, BYPASS, IDCODE and BUILD ID registers,
// TDO stage and the external debug scan chain port

`timescale 1ns/1ps

module tapc_top (
    input  logic                                      tapc_tck,
    input  logic                                      tapc_trst_n,
    input  logic                                      tapc_tms_i,
    input  logic                                      tapc_tdi_i,
    input  logic [tapc_pkg::TAPC_DR_IDCODE_WIDTH-1:0] fuse_idcode_i,
    input  logic                                      chain_tdo_i,
    output tapc_pkg::tapc_chain_ctrl_t                chain_ctrl_o,
    output logic                                      tapc_tdo_o,
    output logic                                      tapc_tdo_en_o
);
    import tapc_pkg::*;

    // FSM outputs
    tapc_dr_ctrl_t               dr_ctrl;
    logic                        ir_capture;
    logic                        ir_shift;
    logic                        ir_update;
    logic                        ir_shift_q;
    logic                        soft_rst_n;

    // Instruction path outputs
    tapc_dr_sel_t                dr_sel;
    logic [TAPC_CH_ID_WIDTH-1:0] ch_id;
    logic                        ir_tdo;

    // Serial outs of the local data registers
    logic                        bypass_tdo;
    logic                        idcode_tdo;
    logic                        bld_id_tdo;

    // --------------------
    // Control
    // --------------------
    tapc_fsm u_fsm (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tms_i        (tapc_tms_i),
        .dr_ctrl_o    (dr_ctrl),
        .ir_capture_o (ir_capture),
        .ir_shift_o   (ir_shift),
        .ir_update_o  (ir_update),
        .ir_shift_q_o (ir_shift_q),
        .soft_rst_n_o (soft_rst_n)
    );

    tapc_ir u_ir (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .soft_rst_n_i (soft_rst_n),
        .tdi_i        (tapc_tdi_i),
        .ir_capture_i (ir_capture),
        .ir_shift_i   (ir_shift),
        .ir_update_i  (ir_update),
        .ir_tdo_o     (ir_tdo),
        .dr_sel_o     (dr_sel),
        .ch_id_o      (ch_id)
    );

    // --------------------
    // Data registers
    // --------------------
    // Mandatory 1-bit bypass, captures zero
    tapc_dr_chain #(.WIDTH(TAPC_DR_BYPASS_WIDTH)) u_bypass_dr (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .soft_rst_n_i (soft_rst_n),
        .sel_i        (dr_sel.bypass),
        .dr_ctrl_i    (dr_ctrl),
        .tdi_i        (tapc_tdi_i),
        .parallel_i   (1'b0),
        .tdo_o        (bypass_tdo)
    );

    // Device id from fuses
    tapc_dr_chain #(.WIDTH(TAPC_DR_IDCODE_WIDTH)) u_idcode_dr (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .soft_rst_n_i (soft_rst_n),
        .sel_i        (dr_sel.idcode),
        .dr_ctrl_i    (dr_ctrl),
        .tdi_i        (tapc_tdi_i),
        .parallel_i   (fuse_idcode_i),
        .tdo_o        (idcode_tdo)
    );

    tapc_dr_chain #(.WIDTH(TAPC_DR_BLD_ID_WIDTH)) u_bld_id_dr (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .soft_rst_n_i (soft_rst_n),
        .sel_i        (dr_sel.bld_id),
        .dr_ctrl_i    (dr_ctrl),
        .tdi_i        (tapc_tdi_i),
        .parallel_i   (TAPC_BLD_ID_VALUE),
        .tdo_o        (bld_id_tdo)
    );

    tapc_tdo_mux u_tdo_mux (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .soft_rst_n_i (soft_rst_n),
        .dr_sel_i     (dr_sel),
        .dr_ctrl_i    (dr_ctrl),
        .ir_shift_q_i (ir_shift_q),
        .ir_tdo_i     (ir_tdo),
        .bypass_tdo_i (bypass_tdo),
        .idcode_tdo_i (idcode_tdo),
        .bld_id_tdo_i (bld_id_tdo),
        .chain_tdo_i  (chain_tdo_i),
        .tdo_o        (tapc_tdo_o),
        .tdo_en_o     (tapc_tdo_en_o)
    );

    // Chain port, strobes shared with the local registers
    assign chain_ctrl_o.dmi_sel = dr_sel.dmi;
    assign chain_ctrl_o.scu_sel = dr_sel.scu;
    assign chain_ctrl_o.ch_id   = ch_id;
    assign chain_ctrl_o.capture = dr_ctrl.capture;
    assign chain_ctrl_o.shift   = dr_ctrl.shift;
    assign chain_ctrl_o.update  = dr_ctrl.update;
    assign chain_ctrl_o.tdi     = tapc_tdi_i;

endmodule : tapc_top

// File: run_sim.sh
#!/bin/sh
# Build and run the TAP controller testbench with Verilator

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tapc.f --top-module tapc_tb -Mdir "$OBJ" -o tapc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/tapc_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// File: sim/tapc_model.svh
// Reference model of the TAP controller for the testbench
// Steps the state from TMS and tracks IR and data register contents

`ifndef TAPC_MODEL_SVH
`define TAPC_MODEL_SVH

tapc_state_e m_state;
tapc_state_e m_prev_state;
tapc_instr_t m_instr;
tapc_instr_t m_ir_sr;
logic        m_byp;
logic [31:0] m_idc;
logic [31:0] m_bld;
// Chain TDO as the falling-edge register sees it, one cycle behind the drive
logic        m_chain_q;

task automatic model_reset();
    m_state      = TAPC_ST_RESET;
    m_prev_state = TAPC_ST_RESET;
    m_instr      = TAPC_INSTR_IDCODE;
    m_ir_sr      = '0;
    m_byp        = 1'b0;
    m_idc        = '0;
    m_bld        = '0;
    m_chain_q    = 1'b0;
endtask

// Next state, grouped by TMS value
function automatic tapc_state_e next_state(tapc_state_e s, logic tms_v);
    tapc_state_e nxt;
    if (tms_v) begin
        case (s)
            TAPC_ST_RESET, TAPC_ST_IR_SEL:                      nxt = TAPC_ST_RESET;
            TAPC_ST_IDLE, TAPC_ST_DR_UPDATE, TAPC_ST_IR_UPDATE: nxt = TAPC_ST_DR_SEL;
            TAPC_ST_DR_SEL:                                     nxt = TAPC_ST_IR_SEL;
            TAPC_ST_DR_CAPTURE, TAPC_ST_DR_SHIFT:               nxt = TAPC_ST_DR_EXIT1;
            TAPC_ST_DR_EXIT1, TAPC_ST_DR_EXIT2:                 nxt = TAPC_ST_DR_UPDATE;
            TAPC_ST_DR_PAUSE:                                   nxt = TAPC_ST_DR_EXIT2;
            TAPC_ST_IR_CAPTURE, TAPC_ST_IR_SHIFT:               nxt = TAPC_ST_IR_EXIT1;
            TAPC_ST_IR_EXIT1, TAPC_ST_IR_EXIT2:                 nxt = TAPC_ST_IR_UPDATE;
            default:                                            nxt = TAPC_ST_IR_EXIT2;
        endcase
    end else begin
        case (s)
            TAPC_ST_RESET, TAPC_ST_IDLE:                        nxt = TAPC_ST_IDLE;
            TAPC_ST_DR_UPDATE, TAPC_ST_IR_UPDATE:               nxt = TAPC_ST_IDLE;
            TAPC_ST_DR_SEL:                                     nxt = TAPC_ST_DR_CAPTURE;
            TAPC_ST_DR_CAPTURE, TAPC_ST_DR_SHIFT:               nxt = TAPC_ST_DR_SHIFT;
            TAPC_ST_DR_EXIT2:                                   nxt = TAPC_ST_DR_SHIFT;
            TAPC_ST_DR_EXIT1, TAPC_ST_DR_PAUSE:                 nxt = TAPC_ST_DR_PAUSE;
            TAPC_ST_IR_SEL:                                     nxt = TAPC_ST_IR_CAPTURE;
            TAPC_ST_IR_CAPTURE, TAPC_ST_IR_SHIFT:               nxt = TAPC_ST_IR_SHIFT;
            TAPC_ST_IR_EXIT2:                                   nxt = TAPC_ST_IR_SHIFT;
            default:                                            nxt = TAPC_ST_IR_PAUSE;
        endcase
    end
    return nxt;
endfunction

function automatic logic is_chain_instr(tapc_instr_t code);
    return code inside {TAPC_INSTR_SCU_ACCESS, TAPC_INSTR_DTMCS, TAPC_INSTR_DMI_ACCESS};
endfunction

// Serial bit of the selected data source, unlisted codes read bypass
function automatic logic expected_dr_bit();
    if (m_instr == TAPC_INSTR_IDCODE) begin
        return m_idc[0];
    end else if (m_instr == TAPC_INSTR_BLD_ID) begin
        return m_bld[0];
    end else if (is_chain_instr(m_instr)) begin
        return m_chain_q;
    end
    return m_byp;
endfunction

function automatic tapc_chain_ctrl_t expected_chain(logic tdi_v);
    tapc_chain_ctrl_t c;
    c         = '0;
    c.dmi_sel = (m_instr == TAPC_INSTR_DTMCS) || (m_instr == TAPC_INSTR_DMI_ACCESS);
    c.scu_sel = (m_instr == TAPC_INSTR_SCU_ACCESS);
    if (m_instr == TAPC_INSTR_DTMCS) begin
        c.ch_id = TAPC_CH_ID_DTMCS;
    end else if (m_instr == TAPC_INSTR_DMI_ACCESS) begin
        c.ch_id = TAPC_CH_ID_DMI;
    end
    c.capture = (m_state == TAPC_ST_DR_CAPTURE);
    c.shift   = (m_state == TAPC_ST_DR_SHIFT);
    c.update  = (m_state == TAPC_ST_DR_UPDATE);
    c.tdi     = tdi_v;
    return c;
endfunction

// --------------------
// Falling edge
// --------------------
task automatic model_fall_edge(output logic exp_tdo, output logic exp_en);
    exp_en = (m_state == TAPC_ST_DR_SHIFT) || (m_state == TAPC_ST_IR_SHIFT);
    if (m_state == TAPC_ST_DR_SHIFT) begin
        exp_tdo = expected_dr_bit();
    end else if (m_state == TAPC_ST_IR_SHIFT) begin
        exp_tdo = m_ir_sr[0];
    end else begin
        exp_tdo = 1'b0;
    end
    // Soft reset lands one falling edge after Test-Logic-Reset
    if (m_prev_state == TAPC_ST_RESET) begin
        m_instr = TAPC_INSTR_IDCODE;
    end else if (m_state == TAPC_ST_IR_UPDATE) begin
        m_instr = m_ir_sr;
    end
endtask

// --------------------
// Rising edge
// --------------------
task automatic model_rise_edge(input logic tms_v, input logic tdi_v, input logic ch_v);
    logic sel_idc;
    logic sel_bld;
    logic sel_byp;
    sel_idc = (m_instr == TAPC_INSTR_IDCODE);
    sel_bld = (m_instr == TAPC_INSTR_BLD_ID);
    sel_byp = !sel_idc && !sel_bld && !is_chain_instr(m_instr);
    if (m_state == TAPC_ST_RESET) begin
        m_ir_sr = '0;
        m_byp   = 1'b0;
        m_idc   = '0;
        m_bld   = '0;
    end else if (m_state == TAPC_ST_IR_CAPTURE) begin
        m_ir_sr = TAPC_IR_CAPTURE_VALUE;
    end else if (m_state == TAPC_ST_IR_SHIFT) begin
        m_ir_sr = {tdi_v, m_ir_sr[TAPC_IR_WIDTH-1:1]};
    end else if (m_state == TAPC_ST_DR_CAPTURE) begin
        if (sel_byp) m_byp = 1'b0;
        if (sel_idc) m_idc = fuse;
        if (sel_bld) m_bld = TAPC_BLD_ID_VALUE;
    end else if (m_state == TAPC_ST_DR_SHIFT) begin
        if (sel_byp) m_byp = tdi_v;
        if (sel_idc) m_idc = {tdi_v, m_idc[31:1]};
        if (sel_bld) m_bld = {tdi_v, m_bld[31:1]};
    end
    m_chain_q    = ch_v;
    m_prev_state = m_state;
    m_state      = next_state(m_state, tms_v);
endtask

`endif

// File: sim/tapc_tb.sv
// Testbench for the JTAG TAP controller
// Random TDI, chain TDO and TMS walks with every cycle checked against a model

`timescale 1ns/1ps

module tapc_tb;
    import tapc_pkg::*;

    // Run length in TCK cycles
    // Longest scan is 33 bits plus entry and exit
    localparam int RESET_CYCLES = 8;
    localparam int SCAN_CYCLES  = 40;
    localparam int NUM_SCANS    = 14;
    localparam int WALK_CYCLES  = 200;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_SCANS * SCAN_CYCLES + WALK_CYCLES + 50;

    // IR capture pattern, two LSBs fixed at 01
    localparam logic [31:0] IR_CAPTURE_EXP = 32'h0000_0001;

    logic             tck = 1'b0;
    logic             trst_n;
    logic             tms;
    logic             tdi;
    logic [31:0]      fuse;
    logic             chain_tdo;
    tapc_chain_ctrl_t chain_ctrl;
    logic             tdo;
    logic             tdo_en;

    integer           seed;
    int               cycles = 0;
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               test_errs = 0;

    // Scan results and scratch
    tapc_instr_t      ir_out;
    tapc_instr_t      code;
    logic [31:0]      rnd;
    logic [63:0]      din;
    logic [63:0]      dout;

    `include "tapc_model.svh"

    tapc_top UUT (
        .tapc_tck      (tck),
        .tapc_trst_n   (trst_n),
        .tapc_tms_i    (tms),
        .tapc_tdi_i    (tdi),
        .fuse_idcode_i (fuse),
        .chain_tdo_i   (chain_tdo),
        .chain_ctrl_o  (chain_ctrl),
        .tapc_tdo_o    (tdo),
        .tapc_tdo_en_o (tdo_en)
    );

    always #5 tck = ~tck;

    // Cycle limit from the summed test lengths
    always @(posedge tck) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: scans still running after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = rand_word();
        return r[0];
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_chain(input tapc_chain_ctrl_t got, input tapc_chain_ctrl_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: chain_ctrl_o got %h expected %h", $time, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    // --------------------
    // One TCK cycle
    // --------------------
    task automatic tck_step(input logic tms_v, input logic tdi_v, input logic ch_v,
                            output logic tdo_s);
        logic             exp_tdo;
        logic             exp_en;
        tapc_chain_ctrl_t exp_c;
        @(negedge tck);
        model_fall_edge(exp_tdo, exp_en);
        tms       <= tms_v;
        tdi       <= tdi_v;
        chain_tdo <= ch_v;
        exp_c = expected_chain(tdi_v);
        // Strobes and selects settled and TDI just driven
        #1;
        check_chain(chain_ctrl, exp_c);
        @(posedge tck);
        tdo_s = tdo;
        check_bit("tapc_tdo_o", tdo, exp_tdo);
        check_bit("tapc_tdo_en_o", tdo_en, exp_en);
        model_rise_edge(tms_v, tdi_v, ch_v);
    endtask

    task automatic move(input logic tms_v);
        logic b;
        tck_step(tms_v, rand_bit(), rand_bit(), b);
    endtask

    // From Run-Test/Idle back to Run-Test/Idle
    task automatic scan_ir(input tapc_instr_t din_v, output tapc_instr_t dout_v);
        tapc_instr_t d;
        logic        b;
        d      = din_v;
        dout_v = '0;
        move(1'b1);
        move(1'b1);
        move(1'b0);
        move(1'b0);
        for (int i = 0; i < TAPC_IR_WIDTH; i++) begin
            tck_step(i == TAPC_IR_WIDTH - 1, d[0], rand_bit(), b);
            d      = d >> 1;
            dout_v = {b, dout_v[TAPC_IR_WIDTH-1:1]};
        end
        move(1'b1);
        move(1'b0);
    endtask

    // Shifts n bits LSB first with chain TDO bits driven alongside
    task automatic scan_dr(input int n, input logic [63:0] din_v, input logic [63:0] ch_v,
                           output logic [63:0] dout_v);
        logic [63:0] d;
        logic [63:0] c;
        logic        b;
        d      = din_v;
        c      = ch_v;
        dout_v = '0;
        move(1'b1);
        move(1'b0);
        move(1'b0);
        for (int i = 0; i < n; i++) begin
            tck_step(i == n - 1, d[0], c[0], b);
            d      = d >> 1;
            c      = c >> 1;
            dout_v = {b, dout_v[63:1]};
        end
        dout_v = dout_v >> (64 - n);
        move(1'b1);
        move(1'b0);
    endtask

    function automatic logic is_listed(tapc_instr_t c);
        return c inside {TAPC_INSTR_IDCODE, TAPC_INSTR_BLD_ID, TAPC_INSTR_SCU_ACCESS,
                         TAPC_INSTR_DTMCS, TAPC_INSTR_DMI_ACCESS, TAPC_INSTR_BYPASS};
    endfunction

    task automatic chain_port_test(input tapc_instr_t instr);
        tapc_instr_t cap;
        logic [63:0] c;
        logic [63:0] q;
        scan_ir(instr, cap);
        check_word("tapc_tdo_o ir capture", {27'd0, cap}, IR_CAPTURE_EXP);
        c = {rand_word(), rand_word()};
        scan_dr(33, {rand_word(), rand_word()}, c, q);
        // Chain bits reach TDO one cycle late
        check_word("tapc_tdo_o chain data", q[32:1], c[31:0]);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("Test %0d %s: pass", tests, name);
        end else begin
            $display("Test %0d %s: %0d mismatches", tests, name, test_errs);
        end
        test_errs = 0;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        seed = 8;
        trst_n    <= 1'b0;
        tms       <= 1'b1;
        tdi       <= 1'b0;
        chain_tdo <= 1'b0;
        fuse      <= rand_word();
        model_reset();
        repeat (RESET_CYCLES) @(negedge tck);
        trst_n <= 1'b1;
        move(1'b0);

        // IDCODE selected straight out of reset
        scan_dr(32, {rand_word(), rand_word()}, {rand_word(), rand_word()}, dout);
        check_word("tapc_tdo_o idcode", dout[31:0], fuse);
        end_test("IDCODE after reset");

        scan_ir(TAPC_INSTR_BYPASS, ir_out);
        check_word("tapc_tdo_o ir capture", {27'd0, ir_out}, IR_CAPTURE_EXP);
        din = {rand_word(), rand_word()};
        scan_dr(33, din, {rand_word(), rand_word()}, dout);
        check_bit("tapc_tdo_o bypass first", dout[0], 1'b0);
        check_word("tapc_tdo_o bypass data", dout[32:1], din[31:0]);
        end_test("IR capture and BYPASS");

        scan_ir(TAPC_INSTR_BLD_ID, ir_out);
        scan_dr(32, {rand_word(), rand_word()}, {rand_word(), rand_word()}, dout);
        check_word("tapc_tdo_o build id", dout[31:0], TAPC_BLD_ID_VALUE);
        do begin
            rnd  = rand_word();
            code = rnd[4:0];
        end while (is_listed(code));
        scan_ir(code, ir_out);
        din = {rand_word(), rand_word()};
        scan_dr(33, din, {rand_word(), rand_word()}, dout);
        check_bit("tapc_tdo_o unknown first", dout[0], 1'b0);
        check_word("tapc_tdo_o unknown data", dout[32:1], din[31:0]);
        end_test("BUILD ID and unknown code");

        chain_port_test(TAPC_INSTR_DTMCS);
        chain_port_test(TAPC_INSTR_DMI_ACCESS);
        chain_port_test(TAPC_INSTR_SCU_ACCESS);
        end_test("DTMCS, DMI and SCU chain port");

        repeat (WALK_CYCLES) move(rand_bit());
        // Five TMS high from any state reach Test-Logic-Reset
        repeat (5) move(1'b1);
        move(1'b0);
        scan_dr(32, {rand_word(), rand_word()}, {rand_word(), rand_word()}, dout);
        check_word("tapc_tdo_o idcode after walk", dout[31:0], fuse);
        end_test("Random TMS walk and soft reset");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tapc_tb

// File: tapc.f
+incdir+sim
hdl/tapc_pkg.sv
hdl/tapc_fsm.sv
hdl/tapc_ir.sv
hdl/tapc_dr_chain.sv
hdl/tapc_tdo_mux.sv
hdl/tapc_top.sv
sim/tapc_tb.sv
